// ==== logic/nand_pkg.sv ====
// Shared host command codes, bus and request structs and NAND constants, imported by the RTL
package nand_pkg;

	// Host command codes seen on cmd_in
	// Codes 14 and 15 are unused and fall back to idle
	typedef enum logic [3:0] {
		NAND_RESET     = 4'h0,
		READ_STATUS    = 4'h1,
		READ_ID        = 4'h2,
		CHIP_ENABLE    = 4'h3,
		CHIP_DISABLE   = 4'h4,
		WRITE_PROTECT  = 4'h5,
		WRITE_ENABLE   = 4'h6,
		GET_STATUS     = 4'h7,
		RESET_INDEX    = 4'h8,
		GET_ID_BYTE    = 4'h9,
		BYPASS_COMMAND = 4'hA,
		BYPASS_ADDRESS = 4'hB,
		BYPASS_DATA_WR = 4'hC,
		BYPASS_DATA_RD = 4'hD
	} host_cmd_t;

	// ------------------------------
	// Sequencer to cycle unit requests

	// Single CLE or ALE write
	typedef struct packed {
		logic       valid;
		logic       is_addr;
		logic [7:0] data;
	} latch_req_t;

	// Single data write or read
	typedef struct packed {
		logic       valid;
		logic       write;
		logic [7:0] data;
	} io_req_t;

	// Pin activity of one cycle unit, merged in the pin driver
	typedef struct packed {
		logic       cle;
		logic       ale;
		logic       nwe;
		logic       nre;
		logic [7:0] dout;
		logic       drive;
		logic       busy;
	} nand_bus_t;

	// ------------------------------
	// Status register layout
	// Bits 0 and 1 always read 0
	localparam int STAT_CHIP_EN = 2;
	localparam int STAT_WPROT   = 3;
	localparam int STAT_RANGE   = 4;
	// Write protected out of reset
	localparam logic [7:0] STATUS_RESET = 8'h08;

	// NAND command bytes
	localparam logic [7:0] CMD_RESET       = 8'hFF;
	localparam logic [7:0] CMD_READ_STATUS = 8'h70;
	localparam logic [7:0] CMD_READ_ID     = 8'h90;

	// Length of the JEDEC ID buffer
	localparam int ID_BYTES = 5;

endpackage

// ==== logic/nand_latch_cycle.sv ====
// Command and address latch unit; turns one request into a single CLE or ALE write cycle
`timescale 1ns/1ps

module nand_latch_cycle
	import nand_pkg::*;
#(
	parameter int WE_LOW  = 2,
	parameter int WE_HIGH = 2
) (
	input  logic       clk,
	input  logic       nreset,
	input  latch_req_t req,
	output nand_bus_t  bus
);

	localparam int TOTAL = WE_LOW + WE_HIGH;
	localparam int CW    = $clog2(TOTAL + 1);

	logic          busy;
	logic [CW-1:0] cnt;
	logic          is_addr;
	logic [7:0]    data;

	// Cycle counter, busy from the edge after the request for TOTAL clocks
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (!busy) begin
			busy <= req.valid;
			cnt  <= '0;
		end else if (cnt == CW'(TOTAL - 1)) begin
			busy <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Byte and latch kind held for the whole cycle
	always_ff @(posedge clk) begin
		if (req.valid && !busy) begin
			is_addr <= req.is_addr;
			data    <= req.data;
		end
	end

	// CLE or ALE high for the whole cycle, WE# low for the first WE_LOW clocks
	always_comb begin
		bus.cle   = busy && !is_addr;
		bus.ale   = busy && is_addr;
		bus.nwe   = !(busy && (cnt < CW'(WE_LOW)));
		bus.nre   = 1'b1;
		bus.dout  = data;
		bus.drive = busy;
		bus.busy  = busy;
	end

	// Sequencer waits for the previous cycle to finish
	a_no_req_busy: assert property (@(posedge clk) disable iff (!nreset)
		req.valid |-> !busy);

endmodule

// ==== logic/nand_io_cycle.sv ====
// Data IO unit; turns one request into a single data write cycle or data read cycle
`timescale 1ns/1ps

module nand_io_cycle
	import nand_pkg::*;
#(
	parameter int WE_LOW  = 2,
	parameter int WE_HIGH = 2
) (
	input  logic       clk,
	input  logic       nreset,
	input  io_req_t    req,
	input  logic [7:0] din,
	output nand_bus_t  bus,
	output logic [7:0] rd_byte
);

	localparam int TOTAL = WE_LOW + WE_HIGH;
	localparam int CW    = $clog2(TOTAL + 1);
	// Pin output and input registers add one clock each
	// Last low clock at the pins shows up in din one clock after RE# is released here
	// Needs WE_HIGH of at least 2
	localparam int CAP = WE_LOW + 1;

	logic          busy;
	logic [CW-1:0] cnt;
	logic          write;
	logic [7:0]    data;
	logic          strobe;

	// Cycle counter
	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (!busy) begin
			busy <= req.valid;
			cnt  <= '0;
		end else if (cnt == CW'(TOTAL - 1)) begin
			busy <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Direction and write byte, plus the read capture
	always_ff @(posedge clk) begin
		if (req.valid && !busy) begin
			write <= req.write;
			data  <= req.data;
		end
		if (busy && !write && (cnt == CW'(CAP))) begin
			rd_byte <= din;
		end
	end

	// Low phase of WE# or RE#
	assign strobe = busy && (cnt < CW'(WE_LOW));

	// Writes drive the bus, reads leave it to the chip
	always_comb begin
		bus.cle   = 1'b0;
		bus.ale   = 1'b0;
		bus.nwe   = !(strobe && write);
		bus.nre   = !(strobe && !write);
		bus.dout  = data;
		bus.drive = busy && write;
		bus.busy  = busy;
	end

	a_no_req_busy: assert property (@(posedge clk) disable iff (!nreset)
		req.valid |-> !busy);

endmodule

// ==== logic/nand_pin_driver.sv ====
// NAND pin stage; merges both cycle units onto registered pins and synchronizes ready/busy
`timescale 1ns/1ps

module nand_pin_driver
	import nand_pkg::*;
(
	input  logic       clk,
	input  logic       nreset,
	input  nand_bus_t  latch_bus,
	input  nand_bus_t  io_bus,
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	inout  logic [7:0] nand_data,
	output logic [7:0] din,
	input  logic       nand_rnb,
	output logic       rnb_sync
);

	logic [7:0] dout_q;
	logic       oe_q;
	logic [1:0] rnb_q;

	// Control pins, idle levels out of reset
	always_ff @(posedge clk) begin
		if (!nreset) begin
			nand_cle <= 1'b0;
			nand_ale <= 1'b0;
			nand_nwe <= 1'b1;
			nand_nre <= 1'b1;
			oe_q     <= 1'b0;
			rnb_q    <= '0;
		end else begin
			nand_cle <= latch_bus.cle | io_bus.cle;
			nand_ale <= latch_bus.ale | io_bus.ale;
			// Active low, so either unit pulls it down
			nand_nwe <= latch_bus.nwe & io_bus.nwe;
			nand_nre <= latch_bus.nre & io_bus.nre;
			oe_q     <= latch_bus.drive | io_bus.drive;
			rnb_q    <= {rnb_q[0], nand_rnb};
		end
	end

	// Outgoing byte from whichever unit drives, incoming byte sampled every clock
	always_ff @(posedge clk) begin
		dout_q <= latch_bus.drive ? latch_bus.dout : io_bus.dout;
		din    <= nand_data;
	end

	// Bus floats unless a write or latch cycle owns it
	assign nand_data = oe_q ? dout_q : 8'bz;
	assign rnb_sync  = rnb_q[1];

	// Only one unit may own the pins at a time
	a_one_owner: assert property (@(posedge clk) disable iff (!nreset)
		!(latch_bus.busy && io_bus.busy));

endmodule

// ==== logic/nand_sequencer.sv ====
// Host command interpreter and NAND operation sequencer, with status, index and ID registers
`timescale 1ns/1ps

module nand_sequencer
	import nand_pkg::*;
#(
	parameter int T_WB  = 4,
	parameter int T_WHR = 6
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  host_cmd_t  cmd_in,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       busy,
	output logic       nand_nce,
	output logic       nand_nwp,
	output latch_req_t latch_req,
	output io_req_t    io_req,
	input  logic       latch_busy,
	input  logic       io_busy,
	input  logic [7:0] rd_byte,
	input  logic       rnb_sync
);

	localparam int DLY_MAX = (T_WB > T_WHR) ? T_WB : T_WHR;
	localparam int DW      = $clog2(DLY_MAX + 1);
	localparam int IW      = $clog2(ID_BYTES + 1);

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_WAIT} seq_state_t;

	seq_state_t    state;
	host_cmd_t     cmd_q;
	logic [2:0]    step;
	logic [DW-1:0] dly;
	logic [7:0]    data_q;
	logic [7:0]    status;
	logic [IW-1:0] idx;
	logic [7:0]    id_buf [ID_BYTES];
	logic          issue;
	logic          id_we;

	assign busy = (state != ST_IDLE);

	// ------------------------------
	// Unit requests with one clock per step
	always_comb begin
		latch_req = '0;
		io_req    = '0;
		if (state == ST_RUN) begin
			case (cmd_q)
				NAND_RESET, BYPASS_COMMAND: begin
					latch_req.valid = (step == 3'd0);
					latch_req.data  = (cmd_q == NAND_RESET) ? CMD_RESET : data_q;
				end
				READ_STATUS: begin
					latch_req.valid = (step == 3'd0);
					latch_req.data  = CMD_READ_STATUS;
					io_req.valid    = (step == 3'd2);
				end
				READ_ID: begin
					// Command 90, then address 00, then one read per ID byte
					latch_req.valid   = (step == 3'd0) || (step == 3'd1);
					latch_req.is_addr = (step == 3'd1);
					latch_req.data    = (step == 3'd0) ? CMD_READ_ID : 8'h00;
					io_req.valid      = (step == 3'd3);
				end
				BYPASS_ADDRESS: begin
					latch_req.valid   = (step == 3'd0);
					latch_req.is_addr = 1'b1;
					latch_req.data    = data_q;
				end
				BYPASS_DATA_WR: begin
					io_req.valid = (step == 3'd0);
					io_req.write = 1'b1;
					io_req.data  = data_q;
				end
				BYPASS_DATA_RD: begin
					io_req.valid = (step == 3'd0);
				end
				default: begin
				end
			endcase
		end
	end

	assign issue = latch_req.valid | io_req.valid;
	assign id_we = (state == ST_RUN) && (cmd_q == READ_ID) && (step == 3'd4);

	// Host byte and ID buffer
	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && activate) begin
			data_q <= data_in;
		end
		if (id_we) begin
			id_buf[idx] <= rd_byte;
		end
	end

	// ------------------------------
	// Main FSM
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state    <= ST_IDLE;
			cmd_q    <= NAND_RESET;
			step     <= '0;
			dly      <= '0;
			status   <= STATUS_RESET;
			idx      <= '0;
			data_out <= '0;
			nand_nce <= 1'b1;
			nand_nwp <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (activate) begin
						cmd_q <= cmd_in;
						step  <= '0;
						state <= ST_RUN;
						// ID fill starts at the first byte
						if (cmd_in == READ_ID) begin
							idx <= '0;
						end
					end
				end
				ST_WAIT: begin
					// Delay first, then units idle and chip ready
					if (dly != '0) begin
						dly <= dly - 1'b1;
					end else if (!latch_busy && !io_busy && rnb_sync) begin
						state <= ST_RUN;
					end
				end
				default: begin
					if (issue) begin
						state <= ST_WAIT;
						dly   <= '0;
						step  <= step + 3'd1;
					end else begin
						// Finish unless a step below continues
						state <= ST_IDLE;
						case (cmd_q)
							NAND_RESET, BYPASS_COMMAND: begin
								if (step == 3'd1) begin
									dly   <= DW'(T_WB);
									state <= ST_WAIT;
									step  <= 3'd2;
								end
							end
							READ_STATUS: begin
								if (step == 3'd1) begin
									dly   <= DW'(T_WHR);
									state <= ST_WAIT;
									step  <= 3'd2;
								end else begin
									data_out <= rd_byte;
								end
							end
							READ_ID: begin
								if (step == 3'd2) begin
									dly   <= DW'(T_WHR);
									state <= ST_WAIT;
									step  <= 3'd3;
								end else if (idx == IW'(ID_BYTES - 1)) begin
									idx <= '0;
								end else begin
									// Next ID byte
									idx   <= idx + 1'b1;
									state <= ST_RUN;
									step  <= 3'd3;
								end
							end
							BYPASS_DATA_RD: data_out <= rd_byte;
							CHIP_ENABLE: begin
								nand_nce             <= 1'b0;
								status[STAT_CHIP_EN] <= 1'b1;
							end
							CHIP_DISABLE: begin
								nand_nce             <= 1'b1;
								status[STAT_CHIP_EN] <= 1'b0;
							end
							WRITE_PROTECT: begin
								nand_nwp           <= 1'b0;
								status[STAT_WPROT] <= 1'b1;
							end
							WRITE_ENABLE: begin
								nand_nwp           <= 1'b1;
								status[STAT_WPROT] <= 1'b0;
							end
							GET_STATUS: data_out <= status;
							RESET_INDEX: idx <= '0;
							GET_ID_BYTE: begin
								if (idx < IW'(ID_BYTES)) begin
									data_out           <= id_buf[idx];
									idx                <= idx + 1'b1;
									status[STAT_RANGE] <= 1'b0;
								end else begin
									// Past the end wraps the index and flags it
									data_out           <= 8'h00;
									idx                <= '0;
									status[STAT_RANGE] <= 1'b1;
								end
							end
							default: begin
							end
						endcase
					end
				end
			endcase
		end
	end

	// A request belongs to a running operation and its unit takes it on the next clock
	a_req_in_op: assert property (@(posedge clk) disable iff (!nreset)
		issue |-> busy ##1 (latch_busy || io_busy));

endmodule

// ==== logic/nand_ctrl_top.sv ====
// NAND controller top level; host command port on one side, 8-bit NAND pins on the other
`timescale 1ns/1ps

module nand_ctrl_top
	import nand_pkg::*;
#(
	parameter int WE_LOW  = 2,
	parameter int WE_HIGH = 2,
	parameter int T_WB    = 4,
	parameter int T_WHR   = 6
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  host_cmd_t  cmd_in,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       busy,
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic       nand_nce,
	output logic       nand_nwp,
	input  logic       nand_rnb,
	inout  logic [7:0] nand_data
);

	latch_req_t latch_req;
	io_req_t    io_req;
	nand_bus_t  latch_bus;
	nand_bus_t  io_bus;
	logic [7:0] rd_byte;
	logic [7:0] din;
	logic       rnb_sync;

	// ------------------------------
	// Operation control
	nand_sequencer #(.T_WB(T_WB), .T_WHR(T_WHR)) u_seq (
		.clk        (clk),
		.nreset     (nreset),
		.activate   (activate),
		.cmd_in     (cmd_in),
		.data_in    (data_in),
		.data_out   (data_out),
		.busy       (busy),
		.nand_nce   (nand_nce),
		.nand_nwp   (nand_nwp),
		.latch_req  (latch_req),
		.io_req     (io_req),
		.latch_busy (latch_bus.busy),
		.io_busy    (io_bus.busy),
		.rd_byte    (rd_byte),
		.rnb_sync   (rnb_sync)
	);

	// Cycle units side by side
	nand_latch_cycle #(.WE_LOW(WE_LOW), .WE_HIGH(WE_HIGH)) u_latch (
		.clk    (clk),
		.nreset (nreset),
		.req    (latch_req),
		.bus    (latch_bus)
	);

	nand_io_cycle #(.WE_LOW(WE_LOW), .WE_HIGH(WE_HIGH)) u_io (
		.clk     (clk),
		.nreset  (nreset),
		.req     (io_req),
		.din     (din),
		.bus     (io_bus),
		.rd_byte (rd_byte)
	);

	// Pin stage
	nand_pin_driver u_pins (
		.clk       (clk),
		.nreset    (nreset),
		.latch_bus (latch_bus),
		.io_bus    (io_bus),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_nwe  (nand_nwe),
		.nand_nre  (nand_nre),
		.nand_data (nand_data),
		.din       (din),
		.nand_rnb  (nand_rnb),
		.rnb_sync  (rnb_sync)
	);

endmodule

// ==== tests/nand_chip_model.sv ====
// Behavioral 8-bit NAND chip for the controller testbench; logs latched cycles and answers reads
`timescale 1ns/1ps

module nand_chip_model #(
	parameter logic [39:0] ID_WORD     = 40'h3BC1275E94,
	parameter logic [7:0]  STATUS_BYTE = 8'hA5,
	parameter int          BUSY_CYCLES = 20
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       nce,
	input  logic       cle,
	input  logic       ale,
	input  logic       nwe,
	input  logic       nre,
	output logic       rnb,
	inout  wire  [7:0] data,
	input  logic [7:0] rd_data,
	output logic       log_valid,
	output logic [9:0] log_entry
);

	logic       nwe_q;
	logic       nre_q;
	logic [7:0] mode;
	logic [2:0] ptr;
	logic [7:0] rnb_cnt = '0;
	logic [7:0] rd_val;

	// Ready once the reset countdown has run out
	assign rnb = (rnb_cnt == '0);

	// Read answer picked by the last command byte
	always_comb begin
		case (mode)
			8'h70: rd_val = STATUS_BYTE;
			8'h90: rd_val = (ptr < 3'd5) ? ID_WORD[8 * (4 - ptr) +: 8] : 8'h00;
			default: rd_val = rd_data;
		endcase
	end

	// Chip drives the bus only while selected and RE# is low
	assign data = (!nce && !nre) ? rd_val : 8'hzz;

	// ------------------------------
	// Pins sampled on the clock, edges found against the previous sample
	always @(posedge clk) begin
		if (!nreset) begin
			nwe_q     <= 1'b1;
			nre_q     <= 1'b1;
			mode      <= '0;
			ptr       <= '0;
			rnb_cnt   <= '0;
			log_valid <= 1'b0;
			log_entry <= '0;
		end else begin
			nwe_q     <= nwe;
			nre_q     <= nre;
			log_valid <= 1'b0;
			if (rnb_cnt != '0) begin
				rnb_cnt <= rnb_cnt - 1'b1;
			end
			// Rising WE# latches one cycle, kind from CLE and ALE
			if (!nce && !nwe_q && nwe) begin
				log_valid <= 1'b1;
				log_entry <= {cle, ale, data};
				if (cle) begin
					mode <= data;
					ptr  <= '0;
					// Reset holds R/B# low
					if (data == 8'hFF) begin
						rnb_cnt <= 8'(BUSY_CYCLES);
					end
				end
			end
			// Rising RE# steps to the next ID byte
			if (!nce && !nre_q && nre && (ptr < 3'd5)) begin
				ptr <= ptr + 1'b1;
			end
		end
	end

endmodule

// ==== tests/nand_ctrl_tb.sv ====
// Testbench for the NAND controller top level; runs the host commands against a chip model
`timescale 1ns/1ps

module nand_ctrl_tb
	import nand_pkg::*;
();

	localparam int          RESET_CYCLES = 8;
	localparam int          N_CMDS       = 29;
	localparam int          TIMEOUT      = RESET_CYCLES + N_CMDS * 100;
	localparam int          BUSY_CYCLES  = 20;
	localparam logic [39:0] ID_WORD      = 40'h3BC1275E94;
	localparam logic [7:0]  STATUS_BYTE  = 8'hA5;

	// Reference view of the controller and chip
	typedef struct packed {
		logic       ce;
		logic       wp;
		logic       range;
		logic [2:0] idx;
		logic [7:0] last;
	} ref_state_t;

	// Expected outcome of one command
	// Log entries are {cle, ale, byte}
	typedef struct packed {
		ref_state_t next;
		logic       rd_valid;
		logic [7:0] rd;
		logic [1:0] n_log;
		logic [9:0] log0;
		logic [9:0] log1;
	} ref_out_t;

	logic       clk;
	logic       nreset;
	logic       activate;
	host_cmd_t  cmd_in;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic       busy;
	logic       nand_cle;
	logic       nand_ale;
	logic       nand_nwe;
	logic       nand_nre;
	logic       nand_nce;
	logic       nand_nwp;
	logic       nand_rnb;
	wire  [7:0] nand_data;

	logic       log_valid;
	logic [9:0] log_entry;
	logic [7:0] chip_byte;

	logic [31:0] lfsr;
	ref_state_t  ref_s;
	logic [9:0]  exp_log [$];
	logic [8:0]  exp_rd [$];
	logic [9:0]  log_exp;
	logic [8:0]  rd_exp;
	logic [7:0]  held_rd;
	logic        held_valid;
	logic        busy_q;
	int          checks;
	int          errors;
	int          cycles;

	logic [7:0] b_cmd;
	logic [7:0] b_addr;
	logic [7:0] b_wr;

	nand_ctrl_top nand_ctrl_top_i (
		.clk       (clk),
		.nreset    (nreset),
		.activate  (activate),
		.cmd_in    (cmd_in),
		.data_in   (data_in),
		.data_out  (data_out),
		.busy      (busy),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_nwe  (nand_nwe),
		.nand_nre  (nand_nre),
		.nand_nce  (nand_nce),
		.nand_nwp  (nand_nwp),
		.nand_rnb  (nand_rnb),
		.nand_data (nand_data)
	);

	nand_chip_model #(
		.ID_WORD     (ID_WORD),
		.STATUS_BYTE (STATUS_BYTE),
		.BUSY_CYCLES (BUSY_CYCLES)
	) chip_i (
		.clk       (clk),
		.nreset    (nreset),
		.nce       (nand_nce),
		.cle       (nand_cle),
		.ale       (nand_ale),
		.nwe       (nand_nwe),
		.nre       (nand_nre),
		.rnb       (nand_rnb),
		.data      (nand_data),
		.rd_data   (chip_byte),
		.log_valid (log_valid),
		.log_entry (log_entry)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// ------------------------------
	// Random bytes and reference

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	// First ID byte sits in the top of the word
	function automatic logic [7:0] id_byte(input int n);
		return ID_WORD[8 * (4 - n) +: 8];
	endfunction

	function automatic ref_out_t predict(input ref_state_t s, input host_cmd_t cmd,
			input logic [7:0] arg, input logic [7:0] chip_rd);
		ref_out_t r;
		r      = '0;
		r.next = s;
		case (cmd)
			NAND_RESET: begin
				r.n_log     = 2'd1;
				r.log0      = {2'b10, 8'hFF};
				r.next.last = 8'hFF;
			end
			READ_STATUS: begin
				r.n_log     = 2'd1;
				r.log0      = {2'b10, 8'h70};
				r.next.last = 8'h70;
				r.rd_valid  = 1'b1;
				r.rd        = STATUS_BYTE;
			end
			READ_ID: begin
				// Command then a single zero address
				r.n_log     = 2'd2;
				r.log0      = {2'b10, 8'h90};
				r.log1      = {2'b01, 8'h00};
				r.next.last = 8'h90;
				r.next.idx  = '0;
			end
			CHIP_ENABLE:   r.next.ce = 1'b1;
			CHIP_DISABLE:  r.next.ce = 1'b0;
			WRITE_PROTECT: r.next.wp = 1'b1;
			WRITE_ENABLE:  r.next.wp = 1'b0;
			GET_STATUS: begin
				r.rd_valid = 1'b1;
				r.rd       = {3'b000, s.range, s.wp, s.ce, 2'b00};
			end
			RESET_INDEX: r.next.idx = '0;
			GET_ID_BYTE: begin
				r.rd_valid = 1'b1;
				if (s.idx < 3'd5) begin
					r.rd         = id_byte(int'(s.idx));
					r.next.idx   = s.idx + 3'd1;
					r.next.range = 1'b0;
				end else begin
					// Past the end reads zero and wraps
					r.rd         = 8'h00;
					r.next.idx   = '0;
					r.next.range = 1'b1;
				end
			end
			BYPASS_COMMAND: begin
				r.n_log     = 2'd1;
				r.log0      = {2'b10, arg};
				r.next.last = arg;
			end
			BYPASS_ADDRESS: begin
				r.n_log = 2'd1;
				r.log0  = {2'b01, arg};
			end
			BYPASS_DATA_WR: begin
				r.n_log = 2'd1;
				r.log0  = {2'b00, arg};
			end
			BYPASS_DATA_RD: begin
				// Chip answer follows the last command byte it latched
				r.rd_valid = 1'b1;
				if (s.last == 8'h70) begin
					r.rd = STATUS_BYTE;
				end else if (s.last == 8'h90) begin
					r.rd = id_byte(0);
				end else begin
					r.rd = chip_rd;
				end
			end
			default: begin
			end
		endcase
		return r;
	endfunction

	// ------------------------------
	// One host command as a strobe, then wait for busy to drop
	task automatic run_cmd(input host_cmd_t cmd, input logic [7:0] arg);
		ref_out_t r;
		int       rnb_low;
		r = predict(ref_s, cmd, arg, chip_byte);
		if (r.n_log > 2'd0) begin
			exp_log.push_back(r.log0);
		end
		if (r.n_log > 2'd1) begin
			exp_log.push_back(r.log1);
		end
		exp_rd.push_back({r.rd_valid, r.rd});
		rnb_low  = 0;
		activate = 1'b1;
		cmd_in   = cmd;
		data_in  = arg;
		@(posedge clk);
		#1;
		activate = 1'b0;
		checks++;
		if (busy !== 1'b1) begin
			errors++;
			$display("Command %0d did not raise busy", cmd);
		end
		while (busy) begin
			@(posedge clk);
			#1;
			if (!nand_rnb) begin
				rnb_low++;
			end
		end
		ref_s  = r.next;
		checks += 2;
		if (nand_nce !== !ref_s.ce) begin
			errors++;
			$display("Fail nand_nce: expected 0x%0h, got 0x%0h", !ref_s.ce, nand_nce);
		end
		if (nand_nwp !== !ref_s.wp) begin
			errors++;
			$display("Fail nand_nwp: expected 0x%0h, got 0x%0h", !ref_s.wp, nand_nwp);
		end
		// Busy must cover the whole time the chip holds R/B# low
		if (cmd == NAND_RESET) begin
			checks++;
			if (rnb_low != BUSY_CYCLES) begin
				errors++;
				$display("NAND reset saw %0d busy cycles of R/B# low instead of %0d",
					rnb_low, BUSY_CYCLES);
			end
		end
	endtask

	// ------------------------------
	// Compare logged NAND cycles and read results
	always @(posedge clk) begin
		if (log_valid) begin
			if (exp_log.size() == 0) begin
				errors++;
				$display("Chip logged an unexpected cycle 0x%03h", log_entry);
			end else begin
				log_exp = exp_log.pop_front();
				checks++;
				if (log_entry !== log_exp) begin
					errors++;
					$display("Fail nand_log: expected 0x%03h, got 0x%03h", log_exp, log_entry);
				end
			end
		end
		// data_out is valid from the edge where busy fell and holds until the next read
		if (busy_q && !busy) begin
			if (exp_rd.size() == 0) begin
				errors++;
				$display("Busy fell with no command outstanding");
			end else begin
				rd_exp = exp_rd.pop_front();
				if (rd_exp[8]) begin
					held_rd    = rd_exp[7:0];
					held_valid = 1'b1;
				end
				if (held_valid) begin
					checks++;
					if (data_out !== held_rd) begin
						errors++;
						$display("Fail data_out: expected 0x%02h, got 0x%02h",
							held_rd, data_out);
					end
				end
			end
		end
		busy_q = busy;
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped after %0d cycles without finishing the command list", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		clk        = 1'b0;
		nreset     = 1'b0;
		activate   = 1'b0;
		cmd_in     = GET_STATUS;
		data_in    = '0;
		chip_byte  = '0;
		lfsr       = 32'h8674a968;
		ref_s      = '{ce: 1'b0, wp: 1'b1, range: 1'b0, idx: 3'd0, last: 8'h00};
		held_rd    = '0;
		held_valid = 1'b0;
		busy_q     = 1'b0;
		checks     = 0;
		errors     = 0;
		cycles     = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		nreset = 1'b1;
		@(posedge clk);
		#1;

		// Idle pin levels {nce, nwe, nre, nwp, cle, ale, busy}
		checks++;
		if ({nand_nce, nand_nwe, nand_nre, nand_nwp, nand_cle, nand_ale, busy} !== 7'b1110000) begin
			errors++;
			$display("Fail idle_pins: expected 0x70, got 0x%02h",
				{nand_nce, nand_nwe, nand_nre, nand_nwp, nand_cle, nand_ale, busy});
		end
		run_cmd(GET_STATUS, 8'h00);

		// CE# and WP# control
		run_cmd(CHIP_ENABLE, 8'h00);
		run_cmd(GET_STATUS, 8'h00);
		run_cmd(WRITE_ENABLE, 8'h00);
		run_cmd(GET_STATUS, 8'h00);
		run_cmd(CHIP_DISABLE, 8'h00);
		run_cmd(GET_STATUS, 8'h00);
		run_cmd(WRITE_PROTECT, 8'h00);
		run_cmd(GET_STATUS, 8'h00);

		// ID read, then walk the buffer past its end
		run_cmd(CHIP_ENABLE, 8'h00);
		run_cmd(READ_ID, 8'h00);
		run_cmd(RESET_INDEX, 8'h00);
		repeat (6) run_cmd(GET_ID_BYTE, 8'h00);
		run_cmd(GET_STATUS, 8'h00);
		run_cmd(GET_ID_BYTE, 8'h00);
		run_cmd(GET_STATUS, 8'h00);

		// Chip reset and status
		run_cmd(NAND_RESET, 8'h00);
		run_cmd(READ_STATUS, 8'h00);

		// Raw bus cycles with random bytes
		random_byte(b_cmd);
		random_byte(b_addr);
		random_byte(b_wr);
		random_byte(chip_byte);
		run_cmd(BYPASS_COMMAND, b_cmd);
		run_cmd(BYPASS_ADDRESS, b_addr);
		run_cmd(BYPASS_DATA_WR, b_wr);
		run_cmd(BYPASS_DATA_RD, 8'h00);

		// Unused code leaves the status as it was
		run_cmd(host_cmd_t'(4'hE), 8'h00);
		run_cmd(GET_STATUS, 8'h00);

		repeat (4) @(posedge clk);
		if (exp_log.size() != 0) begin
			errors++;
			$display("Chip never logged %0d expected cycles", exp_log.size());
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/nand_pkg.sv
logic/nand_latch_cycle.sv
logic/nand_io_cycle.sv
logic/nand_pin_driver.sv
logic/nand_sequencer.sv
logic/nand_ctrl_top.sv
tests/nand_chip_model.sv
tests/nand_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: nand_ctrl

sources:
  - logic/nand_pkg.sv
  - logic/nand_latch_cycle.sv
  - logic/nand_io_cycle.sv
  - logic/nand_pin_driver.sv
  - logic/nand_sequencer.sv
  - logic/nand_ctrl_top.sv
  - target: test
    files:
      - tests/nand_chip_model.sv
      - tests/nand_ctrl_tb.sv
